// ==== compile.f ====
hw/core_mem_pkg.sv
hw/fetch_unit.sv
hw/load_store_port.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/core_mem_top.sv
dv/core_mem_tb.sv

// ==== dv/core_mem_tb.sv ====
// vectors come from dv/core_mem_vectors.txt relative to the project root; MEM_WORDS must be a power of two
`timescale 1ns/10ps

module core_mem_tb;

    localparam int                  MEM_WORDS = 1024;
    localparam core_mem_pkg::word_t RESET_PC  = 32'h0000_0000;
    localparam int                  BW        = $clog2(MEM_WORDS * 4);
    // cycles any single wait may take
    localparam int                  LIMIT     = 200;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 fetch_en;
    logic                 id_ready;
    logic                 stall_if;
    logic                 pc_src;
    core_mem_pkg::word_t  branch_target;
    core_mem_pkg::word_t  inst;
    core_mem_pkg::word_t  inst_pc;
    logic                 inst_valid;
    logic                 ls_start;
    core_mem_pkg::ls_op_e ls_op;
    core_mem_pkg::word_t  ls_addr;
    core_mem_pkg::word_t  ls_wdata;
    logic                 ls_busy;
    logic                 ls_done;
    logic                 ls_err;
    core_mem_pkg::word_t  ls_rdata;

    // byte-wide reference of the shared memory
    logic [7:0]  ref_mem [MEM_WORDS*4];
    logic [31:0] lfsr_state = 32'h9d81f56f;
    int          errors    = 0;
    int          timeouts  = 0;
    int          file_errs = 0;
    logic        aborted   = 1'b0;

    core_mem_top #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_en      (fetch_en),
        .id_ready      (id_ready),
        .stall_if      (stall_if),
        .pc_src        (pc_src),
        .branch_target (branch_target),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_valid    (inst_valid),
        .ls_start      (ls_start),
        .ls_op         (ls_op),
        .ls_addr       (ls_addr),
        .ls_wdata      (ls_wdata),
        .ls_busy       (ls_busy),
        .ls_done       (ls_done),
        .ls_err        (ls_err),
        .ls_rdata      (ls_rdata)
    );

    always #10 clk = ~clk;

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // word index wraps modulo the depth, lane offset kept
    function automatic logic [BW-1:0] byte_index(input core_mem_pkg::word_t addr);
        return BW'(((addr >> 2) % MEM_WORDS) * 4 + addr[1:0]);
    endfunction

    function automatic core_mem_pkg::word_t ref_word(input core_mem_pkg::word_t addr);
        core_mem_pkg::word_t w;
        core_mem_pkg::word_t base;
        base = {addr[31:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = ref_mem[byte_index(base + 32'(b))];
        end
        return w;
    endfunction

    // little-endian, low byte of the store data at the addressed byte
    task automatic apply_store(input core_mem_pkg::ls_op_e op, input core_mem_pkg::word_t addr,
                               input core_mem_pkg::word_t wdata);
        int n;
        case (op)
            core_mem_pkg::LS_SB: n = 1;
            core_mem_pkg::LS_SH: n = 2;
            core_mem_pkg::LS_SW: n = 4;
            default:             n = 0;
        endcase
        for (int b = 0; b < n; b++) begin
            ref_mem[byte_index(addr + 32'(b))] = wdata[b*8 +: 8];
        end
    endtask

    task automatic check_word(input string name, input core_mem_pkg::word_t exp,
                              input core_mem_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic ls_run(input core_mem_pkg::ls_op_e op, input core_mem_pkg::word_t addr,
                          input core_mem_pkg::word_t wdata, output core_mem_pkg::word_t rdata,
                          output logic err);
        int n;
        rdata = '0;
        err = 1'b0;
        n = 0;
        @(negedge clk);
        while (ls_busy && !aborted) begin
            n++;
            if (n > LIMIT) begin
                $display("timeout: load/store port still busy after %0d cycles", LIMIT);
                timeouts++;
                aborted = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!aborted) begin
            @(posedge clk);
            ls_start <= 1'b1;
            ls_op    <= op;
            ls_addr  <= addr;
            ls_wdata <= wdata;
            @(posedge clk);
            ls_start <= 1'b0;
            n = 0;
            @(negedge clk);
            check_flag("ls_busy after strobe", 1'b1, ls_busy);
            while (!ls_done && !aborted) begin
                n++;
                if (n > LIMIT) begin
                    $display("timeout: no ls_done within %0d cycles of the strobe", LIMIT);
                    timeouts++;
                    aborted = 1'b1;
                end else begin
                    @(negedge clk);
                end
            end
            if (!aborted) begin
                check_flag("ls_busy at done", 1'b1, ls_busy);
            end
            rdata = ls_rdata;
            err = ls_err;
        end
    endtask

    // one-cycle pc_src, any held or in-flight fetch is dropped
    task automatic redirect_to(input core_mem_pkg::word_t target, input int delay);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        pc_src        <= 1'b1;
        branch_target <= target;
        fetch_en      <= 1'b1;
        id_ready      <= 1'b0;
        stall_if      <= 1'b0;
        @(posedge clk);
        pc_src <= 1'b0;
    endtask

    // decode side, random back-pressure
    task automatic deliver(input core_mem_pkg::word_t start, input int count, input string name,
                           input logic stop);
        core_mem_pkg::word_t        exp_pc;
        core_mem_pkg::fetch_state_e fsm;
        int                         got;
        int                         idle;
        logic                       took;
        exp_pc = start;
        got = 0;
        idle = 0;
        took = 1'b0;
        while (got < count && !aborted) begin
            @(negedge clk);
            if (took) begin
                check_flag({name, " valid drop"}, 1'b0, inst_valid);
                took = 1'b0;
            end else if (inst_valid) begin
                check_word({name, " inst_pc"}, exp_pc, inst_pc);
                check_word({name, " inst"}, ref_word(exp_pc), inst);
                took = id_ready && !stall_if;
            end
            @(posedge clk);
            if (took) begin
                got++;
                exp_pc = exp_pc + 32'd4;
                idle = 0;
            end else begin
                idle++;
                if (idle > LIMIT) begin
                    fsm = dut_i.fetch_unit_i.state;
                    $display("timeout: no instruction accepted in %0d cycles, fetch state %s",
                             LIMIT, fsm.name());
                    timeouts++;
                    aborted = 1'b1;
                end
            end
            id_ready <= (rand_bits(2) != 32'd0);
            stall_if <= (rand_bits(2) == 32'd0);
        end
        id_ready <= 1'b0;
        stall_if <= 1'b0;
        if (stop) begin
            fetch_en <= 1'b0;
        end
        if (took && !aborted) begin
            @(negedge clk);
            check_flag({name, " valid drop"}, 1'b0, inst_valid);
        end
    endtask

    // word loads from the program region while fetch runs
    task automatic load_stream(input core_mem_pkg::word_t start, input int count,
                               input int loads, input string name);
        core_mem_pkg::word_t a;
        core_mem_pkg::word_t rd;
        logic                er;
        int                  gap;
        int                  idx;
        for (int k = 0; k < loads && !aborted; k++) begin
            gap = int'(rand_bits(3));
            repeat (gap) @(negedge clk);
            idx = int'(rand_bits(4)) % count;
            a = start + 32'(idx * 4);
            ls_run(core_mem_pkg::LS_LW, a, '0, rd, er);
            check_word($sformatf("%s load %0d", name, k), ref_word(a), rd);
            check_flag($sformatf("%s load %0d err", name, k), 1'b0, er);
        end
    endtask

    initial begin
        int                  fd;
        int                  step;
        int                  op_i;
        int                  exp_err_i;
        int                  n1;
        int                  n2;
        string               cmd;
        string               line;
        string               name;
        core_mem_pkg::word_t a1;
        core_mem_pkg::word_t a2;
        core_mem_pkg::word_t exp_rd;
        core_mem_pkg::word_t rd;
        core_mem_pkg::ls_op_e op;
        logic                er;

        arst_n        <= 1'b0;
        fetch_en      <= 1'b0;
        id_ready      <= 1'b0;
        stall_if      <= 1'b0;
        pc_src        <= 1'b0;
        branch_target <= '0;
        ls_start      <= 1'b0;
        ls_op         <= core_mem_pkg::LS_LW;
        ls_addr       <= '0;
        ls_wdata      <= '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset inst_valid", 1'b0, inst_valid);
        check_flag("reset ls_busy", 1'b0, ls_busy);
        check_flag("reset ls_done", 1'b0, ls_done);
        check_flag("reset ls_err", 1'b0, ls_err);
        check_word("reset pc", RESET_PC, dut_i.fetch_unit_i.if_addr);

        step = 0;
        fd = $fopen("dv/core_mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/core_mem_vectors.txt");
            file_errs++;
        end else begin
            while (!aborted && $fscanf(fd, " %s", cmd) == 1) begin
                if (cmd.substr(0, 0) == "#") begin
                    void'($fgets(line, fd));
                    continue;
                end
                step++;
                name = $sformatf("step %0d", step);
                if (cmd == "L") begin
                    if ($fscanf(fd, "%d %h %h %h %d", op_i, a1, a2, exp_rd, exp_err_i) != 5) begin
                        $display("%s: load/store line is malformed", name);
                        file_errs++;
                        break;
                    end
                    op = core_mem_pkg::ls_op_e'(op_i[2:0]);
                    ls_run(op, a1, a2, rd, er);
                    check_flag({name, " err"}, exp_err_i != 0, er);
                    if (exp_err_i == 0 && !(op inside {core_mem_pkg::LS_SB, core_mem_pkg::LS_SH,
                                                       core_mem_pkg::LS_SW})) begin
                        check_word({name, " rdata"}, exp_rd, rd);
                        if (op == core_mem_pkg::LS_LW) begin
                            check_word({name, " reference"}, ref_word(a1), rd);
                        end
                    end else if (exp_err_i == 0) begin
                        apply_store(op, a1, a2);
                    end
                end else if (cmd == "F") begin
                    if ($fscanf(fd, "%h %d", a1, n1) != 2) begin
                        $display("%s: fetch line is malformed", name);
                        file_errs++;
                        break;
                    end
                    redirect_to(a1, 0);
                    deliver(a1, n1, name, 1'b1);
                end else if (cmd == "R") begin
                    if ($fscanf(fd, "%h %d %h %d", a1, n1, a2, n2) != 4) begin
                        $display("%s: redirect line is malformed", name);
                        file_errs++;
                        break;
                    end
                    redirect_to(a1, 0);
                    deliver(a1, n1, name, 1'b0);
                    // old path keeps fetching a few cycles before the jump
                    redirect_to(a2, int'(rand_bits(2)));
                    deliver(a2, n2, {name, " target"}, 1'b1);
                end else if (cmd == "C") begin
                    if ($fscanf(fd, "%h %d %d", a1, n1, n2) != 3) begin
                        $display("%s: concurrent line is malformed", name);
                        file_errs++;
                        break;
                    end
                    redirect_to(a1, 0);
                    fork
                        deliver(a1, n1, name, 1'b1);
                        load_stream(a1, n1, n2, name);
                    join
                end else begin
                    $display("%s: unknown command %s in the vector file", name, cmd);
                    file_errs++;
                    void'($fgets(line, fd));
                end
            end
            $fclose(fd);
            if (step == 0) begin
                $display("no vector steps were run");
                file_errs++;
            end
        end

        $display("closing: %0d value mismatches, %0d timeouts, %0d vector file errors",
                 errors, timeouts, file_errs);
        if (errors == 0 && timeouts == 0 && file_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/core_mem_vectors.txt ====
# L op addr wdata exp_rdata exp_err, op 0 lb 1 lh 2 lw 3 lbu 4 lhu 5 sb 6 sh 7 sw, values hex
# F pc count | R pc n target m (jump after n) | C pc count loads (loads alongside fetch)
L 7 100 00100093 00000000 0
L 7 104 00200113 00000000 0
L 7 108 00300193 00000000 0
L 7 10c 00400213 00000000 0
L 7 110 00500293 00000000 0
L 7 114 00600313 00000000 0
L 7 200 00a00513 00000000 0
L 7 204 00b00593 00000000 0
L 7 208 00c00613 00000000 0
L 7 20c 00d00693 00000000 0
L 5 400 000000a1 00000000 0
L 5 401 000000b2 00000000 0
L 6 402 0000f4c3 00000000 0
L 2 400 00000000 f4c3b2a1 0
L 6 404 00008765 00000000 0
L 6 406 0000fedc 00000000 0
L 2 404 00000000 fedc8765 0
L 7 408 80ff7f01 00000000 0
L 0 408 00000000 00000001 0
L 0 409 00000000 0000007f 0
L 0 40a 00000000 ffffffff 0
L 0 40b 00000000 ffffff80 0
L 3 408 00000000 00000001 0
L 3 409 00000000 0000007f 0
L 3 40a 00000000 000000ff 0
L 3 40b 00000000 00000080 0
L 1 408 00000000 00007f01 0
L 1 40a 00000000 ffff80ff 0
L 4 408 00000000 00007f01 0
L 4 40a 00000000 000080ff 0
L 1 409 00000000 00000000 1
L 2 40a 00000000 00000000 1
L 6 401 00001111 00000000 1
L 7 402 22222222 00000000 1
L 2 400 00000000 f4c3b2a1 0
L 2 408 00000000 80ff7f01 0
F 100 6
R 100 2 200 3
C 100 6 5
C 200 4 3

// ==== hw/core_mem_pkg.sv ====
// shared types for the memory front end; word-aligned fetch only, no compressed instructions
package core_mem_pkg;

    // one data, address or instruction word
    typedef logic [31:0] word_t;

    // load/store opcodes
    // loads come first, stores last, so the upper bit is not a store flag
    typedef enum logic [2:0] {
        LS_LB  = 3'd0,
        LS_LH  = 3'd1,
        LS_LW  = 3'd2,
        LS_LBU = 3'd3,
        LS_LHU = 3'd4,
        LS_SB  = 3'd5,
        LS_SH  = 3'd6,
        LS_SW  = 3'd7
    } ls_op_e;

    // fetch FSM
    // idle  : request the word at pc
    // wait  : memory data arrives, capture it
    // hold  : instruction presented to decode until accepted
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_WAIT = 2'd1,
        FETCH_HOLD = 2'd2
    } fetch_state_e;

    // which peer owns the shared memory port
    typedef enum logic {
        OWN_FETCH = 1'b0,
        OWN_LSU   = 1'b1
    } mem_owner_e;

endpackage

// ==== hw/core_mem_top.sv ====
// fetch and load/store share one memory port; MEM_WORDS must be a power of two
`timescale 1ns/10ps

module core_mem_top #(
    parameter int                  MEM_WORDS = 1024,
    parameter core_mem_pkg::word_t RESET_PC  = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 fetch_en,
    input  logic                 id_ready,
    input  logic                 stall_if,
    input  logic                 pc_src,
    input  core_mem_pkg::word_t  branch_target,
    output core_mem_pkg::word_t  inst,
    output core_mem_pkg::word_t  inst_pc,
    output logic                 inst_valid,
    input  logic                 ls_start,
    input  core_mem_pkg::ls_op_e ls_op,
    input  core_mem_pkg::word_t  ls_addr,
    input  core_mem_pkg::word_t  ls_wdata,
    output logic                 ls_busy,
    output logic                 ls_done,
    output logic                 ls_err,
    output core_mem_pkg::word_t  ls_rdata
);

    localparam int AW = $clog2(MEM_WORDS);

    // fetch side request
    logic                if_req;
    logic                if_gnt;
    core_mem_pkg::word_t if_addr;

    // load/store side request
    logic                ls_req;
    logic                ls_gnt;
    logic                ls_we;
    logic [3:0]          ls_be;
    core_mem_pkg::word_t ls_req_addr;
    core_mem_pkg::word_t ls_req_wdata;

    // memory port
    logic                mem_en;
    logic                mem_we;
    logic [3:0]          mem_be;
    logic [AW-1:0]       mem_addr;
    core_mem_pkg::word_t mem_wdata;
    core_mem_pkg::word_t mem_rdata;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_en      (fetch_en),
        .id_ready      (id_ready),
        .stall_if      (stall_if),
        .pc_src        (pc_src),
        .branch_target (branch_target),
        .if_req        (if_req),
        .if_addr       (if_addr),
        .if_gnt        (if_gnt),
        .mem_rdata     (mem_rdata),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_valid    (inst_valid)
    );

    load_store_port load_store_port_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .ls_start      (ls_start),
        .ls_op         (ls_op),
        .ls_addr       (ls_addr),
        .ls_wdata      (ls_wdata),
        .ls_busy       (ls_busy),
        .ls_done       (ls_done),
        .ls_err        (ls_err),
        .ls_rdata      (ls_rdata),
        .mem_addr_req  (ls_req_addr),
        .mem_we_req    (ls_we),
        .mem_be_req    (ls_be),
        .mem_wdata_req (ls_req_wdata),
        .ls_req        (ls_req),
        .ls_gnt        (ls_gnt),
        .mem_rdata     (mem_rdata)
    );

    mem_arbiter #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_arbiter_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_gnt    (if_gnt),
        .ls_req    (ls_req),
        .ls_we     (ls_we),
        .ls_be     (ls_be),
        .ls_addr   (ls_req_addr),
        .ls_wdata  (ls_req_wdata),
        .ls_gnt    (ls_gnt),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_be    (mem_be),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    unified_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) unified_mem_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_be    (mem_be),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== hw/fetch_unit.sv ====
// branch_target must be word aligned; one instruction in flight, redirect drops any pending one
`timescale 1ns/10ps

module fetch_unit #(
    parameter core_mem_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                fetch_en,
    input  logic                id_ready,
    input  logic                stall_if,
    input  logic                pc_src,
    input  core_mem_pkg::word_t branch_target,
    output logic                if_req,
    output core_mem_pkg::word_t if_addr,
    input  logic                if_gnt,
    input  core_mem_pkg::word_t mem_rdata,
    output core_mem_pkg::word_t inst,
    output core_mem_pkg::word_t inst_pc,
    output logic                inst_valid
);

    // tag of this peer, shown in assertion messages
    localparam core_mem_pkg::mem_owner_e OWNER = core_mem_pkg::OWN_FETCH;

    core_mem_pkg::fetch_state_e state;
    core_mem_pkg::word_t        pc;
    logic                       accept;

    // decode takes the instruction this cycle
    assign accept = inst_valid & id_ready & ~stall_if;

    assign inst_valid = (state == core_mem_pkg::FETCH_HOLD);

    // no new request on a redirect cycle, the address is about to change
    assign if_req  = (state == core_mem_pkg::FETCH_IDLE) & fetch_en & ~pc_src;
    assign if_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= core_mem_pkg::FETCH_IDLE;
            pc    <= RESET_PC;
        end else if (pc_src) begin
            // redirect from any state, an in-flight read is ignored
            state <= core_mem_pkg::FETCH_IDLE;
            pc    <= branch_target;
        end else begin
            case (state)
                core_mem_pkg::FETCH_IDLE: begin
                    if (if_gnt) begin
                        state <= core_mem_pkg::FETCH_WAIT;
                    end
                end
                core_mem_pkg::FETCH_WAIT: begin
                    state <= core_mem_pkg::FETCH_HOLD;
                end
                core_mem_pkg::FETCH_HOLD: begin
                    if (accept) begin
                        state <= core_mem_pkg::FETCH_IDLE;
                        pc    <= pc + 32'd4;
                    end
                end
                default: begin
                    state <= core_mem_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    // memory data is valid in the cycle after the grant, which is always WAIT
    always_ff @(posedge clk) begin
        if (state == core_mem_pkg::FETCH_WAIT && !pc_src) begin
            inst    <= mem_rdata;
            inst_pc <= pc;
        end
    end

    // back-pressure keeps the presented instruction steady
    assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid && !accept && !pc_src |=> inst_valid && $stable(inst) && $stable(inst_pc))
        else $error("owner %0d: held instruction changed before accept", OWNER);

    // request address must not move until the arbiter grants it
    assert property (@(posedge clk) disable iff (!arst_n)
        if_req && !if_gnt |=> $stable(if_addr))
        else $error("owner %0d: fetch address moved before grant", OWNER);

endmodule

// ==== hw/load_store_port.sv ====
// one access at a time; misaligned halves and words are flagged and never reach memory
`timescale 1ns/10ps

module load_store_port (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 ls_start,
    input  core_mem_pkg::ls_op_e ls_op,
    input  core_mem_pkg::word_t  ls_addr,
    input  core_mem_pkg::word_t  ls_wdata,
    output logic                 ls_busy,
    output logic                 ls_done,
    output logic                 ls_err,
    output core_mem_pkg::word_t  ls_rdata,
    output core_mem_pkg::word_t  mem_addr_req,
    output logic                 mem_we_req,
    output logic [3:0]           mem_be_req,
    output core_mem_pkg::word_t  mem_wdata_req,
    output logic                 ls_req,
    input  logic                 ls_gnt,
    input  core_mem_pkg::word_t  mem_rdata
);

    localparam core_mem_pkg::mem_owner_e OWNER = core_mem_pkg::OWN_LSU;

    core_mem_pkg::ls_op_e op_q;
    core_mem_pkg::word_t  addr_q;
    core_mem_pkg::word_t  wdata_q;
    core_mem_pkg::word_t  lane;
    logic [1:0]           off_q;
    logic                 take;
    logic                 bad_align;

    function automatic logic misaligned(input core_mem_pkg::ls_op_e op, input logic [1:0] off);
        logic bad;
        case (op)
            core_mem_pkg::LS_LH, core_mem_pkg::LS_LHU, core_mem_pkg::LS_SH: bad = off[0];
            core_mem_pkg::LS_LW, core_mem_pkg::LS_SW: bad = |off;
            default: bad = 1'b0;
        endcase
        return bad;
    endfunction

    assign take      = ls_start & ~ls_busy;
    assign bad_align = misaligned(ls_op, ls_addr[1:0]);
    assign off_q     = addr_q[1:0];

    // control, busy spans strobe+1 through the done cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ls_busy <= 1'b0;
            ls_req  <= 1'b0;
            ls_done <= 1'b0;
            ls_err  <= 1'b0;
        end else begin
            ls_done <= ls_gnt | (take & bad_align);
            ls_err  <= take & bad_align;
            if (take) begin
                ls_busy <= 1'b1;
                ls_req  <= ~bad_align;
            end else begin
                if (ls_done) begin
                    ls_busy <= 1'b0;
                end
                if (ls_gnt) begin
                    ls_req <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q    <= ls_op;
            addr_q  <= ls_addr;
            wdata_q <= ls_wdata;
        end
    end

    // request fields come from the registered access, so they hold until grant
    assign mem_addr_req  = {addr_q[31:2], 2'b00};
    assign mem_we_req    = op_q inside {core_mem_pkg::LS_SB, core_mem_pkg::LS_SH,
                                        core_mem_pkg::LS_SW};
    assign mem_wdata_req = wdata_q << {off_q, 3'b000};

    always_comb begin
        case (op_q)
            core_mem_pkg::LS_LB, core_mem_pkg::LS_LBU, core_mem_pkg::LS_SB:
                mem_be_req = 4'b0001 << off_q;
            core_mem_pkg::LS_LH, core_mem_pkg::LS_LHU, core_mem_pkg::LS_SH:
                mem_be_req = 4'b0011 << off_q;
            default:
                mem_be_req = 4'b1111;
        endcase
    end

    // load data, addressed lane moved down then extended
    assign lane = mem_rdata >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            core_mem_pkg::LS_LB:  ls_rdata = {{24{lane[7]}}, lane[7:0]};
            core_mem_pkg::LS_LBU: ls_rdata = {24'h000000, lane[7:0]};
            core_mem_pkg::LS_LH:  ls_rdata = {{16{lane[15]}}, lane[15:0]};
            core_mem_pkg::LS_LHU: ls_rdata = {16'h0000, lane[15:0]};
            core_mem_pkg::LS_LW:  ls_rdata = lane;
            default:              ls_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(ls_start && ls_busy))
        else $error("owner %0d: load/store strobe while busy", OWNER);

endmodule

// ==== hw/mem_arbiter.sv ====
// MEM_WORDS must be a power of two, at least 2; byte addresses wrap modulo the depth
`timescale 1ns/10ps

module mem_arbiter #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         if_req,
    input  core_mem_pkg::word_t          if_addr,
    output logic                         if_gnt,
    input  logic                         ls_req,
    input  logic                         ls_we,
    input  logic [3:0]                   ls_be,
    input  core_mem_pkg::word_t          ls_addr,
    input  core_mem_pkg::word_t          ls_wdata,
    output logic                         ls_gnt,
    output logic                         mem_en,
    output logic                         mem_we,
    output logic [3:0]                   mem_be,
    output logic [$clog2(MEM_WORDS)-1:0] mem_addr,
    output core_mem_pkg::word_t          mem_wdata
);

    localparam int AW = $clog2(MEM_WORDS);

    core_mem_pkg::mem_owner_e last_owner;
    core_mem_pkg::mem_owner_e winner;
    core_mem_pkg::word_t      sel_addr;

    // on a tie the peer not granted last time wins
    always_comb begin
        if (if_req && ls_req) begin
            winner = (last_owner == core_mem_pkg::OWN_FETCH) ? core_mem_pkg::OWN_LSU
                                                              : core_mem_pkg::OWN_FETCH;
        end else if (ls_req) begin
            winner = core_mem_pkg::OWN_LSU;
        end else begin
            winner = core_mem_pkg::OWN_FETCH;
        end
    end

    assign if_gnt = if_req & (winner == core_mem_pkg::OWN_FETCH);
    assign ls_gnt = ls_req & (winner == core_mem_pkg::OWN_LSU);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_owner <= core_mem_pkg::OWN_LSU;
        end else if (if_gnt) begin
            last_owner <= core_mem_pkg::OWN_FETCH;
        end else if (ls_gnt) begin
            last_owner <= core_mem_pkg::OWN_LSU;
        end
    end

    // fetch is always a full-word read
    assign mem_en    = if_gnt | ls_gnt;
    assign mem_we    = ls_gnt & ls_we;
    assign mem_be    = ls_gnt ? ls_be : 4'b1111;
    assign mem_wdata = ls_wdata;
    assign sel_addr  = ls_gnt ? ls_addr : if_addr;
    assign mem_addr  = sel_addr[AW+1:2];

    assert property (@(posedge clk) disable iff (!arst_n) !(if_gnt && ls_gnt))
        else $error("both peers granted in one cycle");

endmodule

// ==== hw/unified_mem.sv ====
// contents are undefined after power-up; a read during a write returns the old word
`timescale 1ns/10ps

module unified_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         mem_en,
    input  logic                         mem_we,
    input  logic [3:0]                   mem_be,
    input  logic [$clog2(MEM_WORDS)-1:0] mem_addr,
    input  core_mem_pkg::word_t          mem_wdata,
    output core_mem_pkg::word_t          mem_rdata
);

    core_mem_pkg::word_t mem_array [MEM_WORDS];

    // per-byte write, done at the request edge
    always_ff @(posedge clk) begin
        if (mem_en && mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_be[b]) begin
                    mem_array[mem_addr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read, data on the following cycle
    always_ff @(posedge clk) begin
        if (mem_en) begin
            mem_rdata <= mem_array[mem_addr];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; the exit status follows the result

set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module core_mem_tb \
    -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vcore_mem_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
